// File: source/cache_pkg.sv
package cache_pkg;

	// cache geometry, same for both l1 caches
	localparam int TAG_W       = 6;
	localparam int SET_W       = 6;
	localparam int WORD_W      = 3;
	localparam int SETS        = 64; // 2**SET_W
	localparam int BLOCK_WORDS = 8;  // 2**WORD_W
	localparam int BLOCK_W     = TAG_W + SET_W; // block number, 12 bits

	// which port_if slot belongs to which cache
	localparam int PORT_D    = 0;
	localparam int PORT_I    = 1;
	localparam int NUM_PORTS = 2;

	// address as seen by the cache lookup
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [SET_W-1:0]  set;
		logic [WORD_W-1:0] word;
		logic              lsb; // not decoded, accesses are whole words
	} lookup_t;

	// same address as seen by the fill path
	typedef struct packed {
		logic [BLOCK_W-1:0] block;
		logic [WORD_W-1:0]  word;
		logic               lsb;
	} block_t;

	// one 16 bit word address, two decodings
	typedef union packed {
		lookup_t lk;
		block_t  bk;
	} addr_t;

	// miss arbiter states
	typedef enum logic [1:0] {
		ARB_IDLE       = 2'b00,
		ARB_I_FILL     = 2'b01, // instruction block being filled
		ARB_D_FILL     = 2'b10, // data block being filled
		ARB_STORE_WAIT = 2'b11  // one cycle for a pending store to reach memory
	} arb_state_t;

	// power-on contents of main memory
	// the testbench model defaults to the same value
	function automatic logic [15:0] mem_init_word(input logic [15:0] addr);
		logic [15:0] val;
		val = addr ^ 16'h5A5A;
		return val;
	endfunction

endpackage

// File: source/port_if.sv
`timescale 1ns/100ps

// one of these per cache: miss report out, fill writes in
interface port_if import cache_pkg::*; ();

	logic              miss;      // level, lookup failed on a valid access
	addr_t             miss_addr; // address of the access that missed
	logic              hold;      // store must wait, memory busy with a fill
	logic              data_we;   // write one returning block word
	logic              tag_we;    // write tag and set valid, last word of the fill
	logic [WORD_W-1:0] fill_word; // word slot inside the block
	logic [15:0]       fill_data;

	modport cache (
		output miss, miss_addr,
		input  hold, data_we, tag_we, fill_word, fill_data
	);

	modport arb (
		input  miss, miss_addr,
		output hold
	);

	modport fill (
		output data_we, tag_we, fill_word, fill_data
	);

endinterface

// File: source/l1_cache.sv
`timescale 1ns/100ps

// direct mapped, 64 sets of 8 words, word addressed
// same module for I and D, the I side gets wr tied low
module l1_cache import cache_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  addr_t       addr,    // pipeline access address
	input  logic        valid,   // access present this cycle
	input  logic        wr,      // store, write through
	input  logic [15:0] wr_data,
	output logic [15:0] rdata,
	port_if.cache       p
);

	localparam int IDX_W = SET_W + WORD_W;

	logic [TAG_W-1:0] tag_mem  [SETS];              // tag array
	logic [SETS-1:0]  vld;                          // valid bits, cleared by reset
	logic [15:0]      data_mem [SETS*BLOCK_WORDS]; // data array

	logic             hit;
	logic             store_ok;
	logic [IDX_W-1:0] rd_idx;   // lookup word index
	logic [IDX_W-1:0] fill_idx; // fill word index

	// the missing address is simply the access address, the pipeline holds it
	assign p.miss_addr = addr;

	// lookup, all combinational
	assign hit    = vld[addr.lk.set] && (tag_mem[addr.lk.set] == addr.lk.tag);
	assign p.miss = valid && !hit;
	assign rd_idx = {addr.lk.set, addr.lk.word};
	assign rdata  = data_mem[rd_idx]; // hit data same cycle as address

	// fill word lands in the set of the missing address
	assign fill_idx = {p.miss_addr.lk.set, p.fill_word};

	// store hit, not held back by the arbiter
	assign store_ok = valid && wr && hit && !p.hold;

	// valid bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld <= '0; // whole cache empty
		end else if (p.tag_we) begin
			vld[p.miss_addr.lk.set] <= 1'b1;
		end
	end

	// tag array
	always_ff @(posedge clk) begin
		if (p.tag_we) begin
			tag_mem[p.miss_addr.lk.set] <= p.miss_addr.lk.tag; // new block owns the set
		end
	end

	// data array, fill has priority
	// a store hit cannot happen during the own fill, the access is missing then
	always_ff @(posedge clk) begin
		if (p.data_we) begin
			data_mem[fill_idx] <= p.fill_data;
		end else if (store_ok) begin
			data_mem[rd_idx] <= wr_data; // memory gets the same word this edge
		end
	end

	// fill words only arrive for an access that is still missing
	a_fill_needs_miss: assert property (
		@(posedge clk) disable iff (!rst_n)
		p.data_we |-> p.miss
	);

	// address held steady, so the new tag matches on the next cycle
	a_miss_clears: assert property (
		@(posedge clk) disable iff (!rst_n)
		p.tag_we |=> !p.miss
	);

endmodule

// File: source/miss_arbiter.sv
`timescale 1ns/100ps

// decides which miss gets the fill controller, D always first
module miss_arbiter import cache_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               store,       // mem_write level from the pipeline
	port_if.arb                arb [NUM_PORTS],
	output logic               start,       // one cycle, first cycle of a fill
	output logic               fill_port,   // port being filled
	output logic [BLOCK_W-1:0] fill_block,  // block number to fetch
	input  logic               done         // last word written
);

	arb_state_t state, state_nx;
	logic       start_nx;
	logic       d_miss, i_miss;
	logic       store_hit;
	logic       filling;

	assign d_miss    = arb[PORT_D].miss;
	assign i_miss    = arb[PORT_I].miss;
	assign store_hit = store && !d_miss;
	assign filling   = (state == ARB_I_FILL) || (state == ARB_D_FILL);

	// store hit waits while the memory port belongs to a fill
	assign arb[PORT_D].hold = filling && store_hit;
	assign arb[PORT_I].hold = 1'b0; // I side never writes

	always_comb begin
		state_nx = state;
		start_nx = 1'b0;
		case (state)
			ARB_IDLE: begin
				if (d_miss) begin
					state_nx = ARB_D_FILL; // data first
					start_nx = 1'b1;
				end else if (i_miss) begin
					state_nx = ARB_I_FILL;
					start_nx = 1'b1;
				end
			end
			ARB_D_FILL: begin
				// d_miss is still up in the done cycle, tag not written yet
				if (done) begin
					if (i_miss && store) begin
						state_nx = ARB_STORE_WAIT; // let the store through first
					end else if (i_miss) begin
						state_nx = ARB_I_FILL;
						start_nx = 1'b1;
					end else begin
						state_nx = ARB_IDLE;
					end
				end
			end
			ARB_I_FILL: begin
				if (done) begin
					if (d_miss) begin
						state_nx = ARB_D_FILL; // chain straight into the data fill
						start_nx = 1'b1;
					end else begin
						state_nx = ARB_IDLE;
					end
				end
			end
			ARB_STORE_WAIT: begin
				if (d_miss) begin
					state_nx = ARB_D_FILL;
					start_nx = 1'b1;
				end else if (i_miss) begin
					state_nx = ARB_I_FILL;
					start_nx = 1'b1;
				end else begin
					state_nx = ARB_IDLE;
				end
			end
			default: state_nx = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ARB_IDLE;
			start <= 1'b0;
		end else begin
			state <= state_nx;
			start <= start_nx;
		end
	end

	// grant payload, captured with the start pulse
	always_ff @(posedge clk) begin
		if (start_nx) begin
			if (state_nx == ARB_D_FILL) begin
				fill_port  <= 1'(PORT_D);
				fill_block <= arb[PORT_D].miss_addr.bk.block;
			end else begin
				fill_port  <= 1'(PORT_I);
				fill_block <= arb[PORT_I].miss_addr.bk.block;
			end
		end
	end

	// the fill controller only finishes a fill that was granted
	a_done_in_fill: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |-> filling
	);

endmodule

// File: source/fill_ctrl.sv
`timescale 1ns/100ps

// block fill sequencer shared by both caches
// reads go out one per cycle, words are written as they come back
module fill_ctrl import cache_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               fill_port,
	input  logic [BLOCK_W-1:0] fill_block,
	output logic               done,
	output logic               rd_en,
	output logic [15:0]        rd_addr,
	input  logic [15:0]        rd_data,
	input  logic               rd_valid,
	port_if.fill               fp [NUM_PORTS]
);

	logic               issuing;   // words 1..7 still to request
	logic [WORD_W-1:0]  issue_cnt; // next word to request
	logic               receiving; // returned-word count not yet complete
	logic [WORD_W-1:0]  recv_cnt;  // next word expected back
	logic [BLOCK_W-1:0] block_q;
	logic               port_q;
	logic               word_in;   // a block word arrives this cycle
	logic               last_word;
	addr_t              rd_a;

	// word 0 goes out in the start cycle itself
	assign rd_en = start || issuing;

	always_comb begin
		rd_a.bk.block = start ? fill_block : block_q;
		rd_a.bk.word  = start ? '0 : issue_cnt;
		rd_a.bk.lsb   = 1'b0;
	end
	assign rd_addr = rd_a;

	assign word_in   = rd_valid && receiving;
	assign last_word = word_in && (recv_cnt == WORD_W'(BLOCK_WORDS - 1));
	assign done      = last_word; // same cycle as tag_we

	// request side
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issuing   <= 1'b0;
			issue_cnt <= '0;
		end else if (start) begin
			issuing   <= 1'b1;
			issue_cnt <= WORD_W'(1);
		end else if (issuing) begin
			issue_cnt <= issue_cnt + 1'b1;
			if (issue_cnt == WORD_W'(BLOCK_WORDS - 1)) begin
				issuing <= 1'b0; // eighth read out
			end
		end
	end

	// return side, counted apart from the requests
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			receiving <= 1'b0;
			recv_cnt  <= '0;
		end else if (start) begin
			receiving <= 1'b1;
			recv_cnt  <= '0;
		end else if (word_in) begin
			recv_cnt <= recv_cnt + 1'b1;
			if (last_word) begin
				receiving <= 1'b0;
			end
		end
	end

	// which block, which cache
	always_ff @(posedge clk) begin
		if (start) begin
			block_q <= fill_block;
			port_q  <= fill_port;
		end
	end

	// steer the returning words to the selected cache only
	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_steer
		assign fp[g].data_we   = word_in && (port_q == 1'(g));
		assign fp[g].tag_we    = last_word && (port_q == 1'(g));
		assign fp[g].fill_word = recv_cnt;
		assign fp[g].fill_data = rd_data;
	end

	// memory never returns more words than were asked for
	a_no_stray_word: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd_valid |-> receiving
	);

	// arbiter waits for done before the next grant
	a_start_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |-> !issuing && !receiving
	);

endmodule

// File: source/main_memory.sv
`timescale 1ns/100ps

// single port main memory, fixed read latency, reads pipelined
module main_memory import cache_pkg::*; #(
	parameter int MEM_LATENCY = 4,     // cycles from rd_en to rd_valid
	parameter int MEM_WORDS   = 65536
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rd_en,
	input  logic [15:0] rd_addr,
	output logic [15:0] rd_data,
	output logic        rd_valid, // one cycle per returned word
	input  logic        wr_en,
	input  logic [15:0] wr_addr,
	input  logic [15:0] wr_data
);

	localparam int ADDR_W = $clog2(MEM_WORDS);

	logic [15:0]            mem [MEM_WORDS];
	logic [MEM_LATENCY-1:0] vld_pipe;              // read valid delay line
	logic [15:0]            dat_pipe [MEM_LATENCY]; // read data delay line

	// preload, every word gets its known value
	initial begin
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = mem_init_word(16'(a));
		end
	end

	// write goes straight into the array
	always @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr[ADDR_W-1:0]] <= wr_data;
		end
	end

	// valid bits, a new read can enter every cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= rd_en;
			for (int s = 1; s < MEM_LATENCY; s++) begin
				vld_pipe[s] <= vld_pipe[s-1];
			end
		end
	end

	// data rides alongside its valid bit
	always_ff @(posedge clk) begin
		dat_pipe[0] <= mem[rd_addr[ADDR_W-1:0]];
		for (int s = 1; s < MEM_LATENCY; s++) begin
			dat_pipe[s] <= dat_pipe[s-1];
		end
	end

	assign rd_valid = vld_pipe[MEM_LATENCY-1];
	assign rd_data  = dat_pipe[MEM_LATENCY-1];

	// arbiter hold keeps store write-through off the port during fills
	a_one_port: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(rd_en && wr_en)
	);

endmodule

// File: source/cache_subsystem.sv
`timescale 1ns/100ps

// memory side of the pipeline: I cache, D cache, one shared fill path
// if mem_stall is up the whole pipe waits, if if_stall only fetch waits
module cache_subsystem import cache_pkg::*; #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS   = 65536
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] pc_addr,
	input  logic [15:0] data_addr,
	input  logic [15:0] data_in,
	input  logic        mem_read,
	input  logic        mem_write,
	output logic        if_stall,
	output logic        mem_stall,
	output logic [15:0] i_out,
	output logic [15:0] d_out
);

	port_if pif [NUM_PORTS] ();

	addr_t              acc_addr  [NUM_PORTS];
	logic               acc_valid [NUM_PORTS];
	logic               acc_wr    [NUM_PORTS];
	logic [15:0]        acc_rdata [NUM_PORTS];

	logic               start, done;
	logic               fill_port;
	logic [BLOCK_W-1:0] fill_block;
	logic               rd_en, rd_valid;
	logic [15:0]        rd_addr, rd_data;
	logic               wr_en;
	logic [15:0]        wr_addr;

	// per port access
	assign acc_addr[PORT_D]  = data_addr;
	assign acc_valid[PORT_D] = mem_read || mem_write;
	assign acc_wr[PORT_D]    = mem_write;
	assign acc_addr[PORT_I]  = pc_addr;
	assign acc_valid[PORT_I] = 1'b1; // fetch every cycle
	assign acc_wr[PORT_I]    = 1'b0;

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_cache
		l1_cache u_cache (
			.clk    (clk),
			.rst_n  (rst_n),
			.addr   (acc_addr[g]),
			.valid  (acc_valid[g]),
			.wr     (acc_wr[g]),
			.wr_data(data_in),
			.rdata  (acc_rdata[g]),
			.p      (pif[g])
		);
	end

	miss_arbiter u_arb (
		.clk       (clk),
		.rst_n     (rst_n),
		.store     (mem_write),
		.arb       (pif),
		.start     (start),
		.fill_port (fill_port),
		.fill_block(fill_block),
		.done      (done)
	);

	fill_ctrl u_fill (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.fill_port (fill_port),
		.fill_block(fill_block),
		.done      (done),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.fp        (pif)
	);

	// write through on a store hit that is not held
	assign wr_en   = mem_write && !pif[PORT_D].miss && !pif[PORT_D].hold;
	assign wr_addr = {data_addr[15:1], 1'b0}; // word aligned like fill reads

	main_memory #(
		.MEM_LATENCY(MEM_LATENCY),
		.MEM_WORDS  (MEM_WORDS)
	) u_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.rd_valid(rd_valid),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (data_in)
	);

	assign if_stall  = pif[PORT_I].miss;
	assign mem_stall = pif[PORT_D].miss || pif[PORT_D].hold;
	assign i_out     = acc_rdata[PORT_I];
	assign d_out     = acc_rdata[PORT_D];

endmodule

// File: test/tb_cache_subsystem.sv
`timescale 1ns/100ps

// directed tests for the cache subsystem, checked against a word model of main memory
// data accesses stay below 16'h8000, fetches stay at 16'hC000 and up, so the
// I cache never holds a block that a store changes
module tb_cache_subsystem import cache_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 6000; // about 150 fills of 13 cycles, plus margin
	localparam int RANDOM_OPS     = 200;

	logic        clk;
	logic        rst_n;
	logic [15:0] pc_addr;
	logic [15:0] data_addr;
	logic [15:0] data_in;
	logic        mem_read;
	logic        mem_write;
	logic        if_stall;
	logic        mem_stall;
	logic [15:0] i_out;
	logic [15:0] d_out;

	logic [15:0] ref_mem [logic [15:0]]; // stored words, everything else still preload
	int          cycles = 0;

	cache_subsystem DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.pc_addr  (pc_addr),
		.data_addr(data_addr),
		.data_in  (data_in),
		.mem_read (mem_read),
		.mem_write(mem_write),
		.if_stall (if_stall),
		.mem_stall(mem_stall),
		.i_out    (i_out),
		.d_out    (d_out)
	);

	always #5 clk = ~clk; // 10 ns period

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			stop_with_error($sformatf("timeout: tests still running after %0d cycles", cycles));
		end
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp) else begin
			stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	// power-on memory word: address xor 5a5a
	function automatic logic [15:0] preload_value(input logic [15:0] addr);
		return addr ^ 16'h5A5A;
	endfunction

	function automatic logic [15:0] model_read(input logic [15:0] addr);
		if (ref_mem.exists(addr)) begin
			return ref_mem[addr];
		end
		return preload_value(addr);
	endfunction

	// tag, set, word slot, low bit always zero
	function automatic logic [15:0] make_addr(input logic [TAG_W-1:0] tag,
			input logic [SET_W-1:0] set_idx, input logic [WORD_W-1:0] word);
		return {tag, set_idx, word, 1'b0};
	endfunction

	// one load, waits out the miss if there is one
	task automatic load_word(input logic [15:0] addr, input logic must_miss);
		@(posedge clk);
		data_addr <= addr;
		mem_read  <= 1'b1;
		@(negedge clk);
		if (must_miss) begin
			check_value("mem_stall", 16'(mem_stall), 16'h0001);
		end
		while (mem_stall) begin
			@(negedge clk);
		end
		check_value("d_out", d_out, model_read(addr));
		@(posedge clk);
		mem_read <= 1'b0;
	endtask

	task automatic store_word(input logic [15:0] addr, input logic [15:0] wdata,
			input logic must_miss);
		@(posedge clk);
		data_addr <= addr;
		data_in   <= wdata;
		mem_write <= 1'b1;
		@(negedge clk);
		if (must_miss) begin
			check_value("mem_stall", 16'(mem_stall), 16'h0001); // allocate first
		end
		while (mem_stall) begin
			@(negedge clk);
		end
		ref_mem[addr] = wdata; // cache and memory take it on the next edge
		@(posedge clk);
		mem_write <= 1'b0;
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		check_value("mem_stall", 16'(mem_stall), 16'h0000); // D port idle
		check_value("if_stall", 16'(if_stall), 16'h0001);   // I cache starts empty
		while (if_stall) begin
			@(negedge clk);
		end
		check_value("i_out", i_out, model_read(pc_addr));
	endtask

	task automatic test_read_fill();
		load_word(make_addr(6'd0, 6'h12, 3'd3), 1'b1); // miss in the middle of a block
		@(posedge clk);
		mem_read <= 1'b1;
		for (int w = 0; w < BLOCK_WORDS; w++) begin
			data_addr <= make_addr(6'd0, 6'h12, 3'(w));
			@(negedge clk);
			check_value("mem_stall", 16'(mem_stall), 16'h0000); // whole block present
			check_value("d_out", d_out, model_read(data_addr));
			@(posedge clk);
		end
		mem_read <= 1'b0;
	endtask

	task automatic test_write_allocate();
		logic [15:0] a;
		logic [15:0] b;
		a = make_addr(6'd0, 6'h24, 3'd5);
		b = make_addr(6'd2, 6'h24, 3'd5); // same set, other tag
		store_word(a, 16'hBEEF, 1'b1);
		load_word(a, 1'b0);
		store_word(a + 16'd2, 16'h1234, 1'b0); // plain store hit
		load_word(b, 1'b1);                    // evicts the block of a
		load_word(a, 1'b1);                    // refetched, memory kept the store
		load_word(a + 16'd2, 1'b0);
	endtask

	task automatic test_priority();
		int d_fall;
		int i_fall;
		int n;
		d_fall = -1;
		i_fall = -1;
		n      = 0;
		@(posedge clk);
		pc_addr   <= 16'hC080; // new I block
		data_addr <= make_addr(6'd0, 6'h36, 3'd2);
		mem_read  <= 1'b1;
		@(negedge clk);
		check_value("mem_stall", 16'(mem_stall), 16'h0001);
		check_value("if_stall", 16'(if_stall), 16'h0001);
		while (d_fall < 0 || i_fall < 0) begin
			if (d_fall < 0 && !mem_stall) begin
				d_fall = n;
				check_value("d_out", d_out, model_read(data_addr));
			end
			if (i_fall < 0 && !if_stall) begin
				i_fall = n;
				check_value("i_out", i_out, model_read(pc_addr));
			end
			n++;
			@(negedge clk);
		end
		assert (d_fall < i_fall) else begin
			stop_with_error("the data miss was not served before the instruction miss");
		end
		@(posedge clk);
		mem_read <= 1'b0;
	endtask

	// one fetch plus one load or store, both checked once their stall is gone
	task automatic run_access(input logic [15:0] pc, input logic [15:0] addr,
			input logic is_store, input logic [15:0] wdata);
		logic d_done;
		logic i_done;
		d_done = 1'b0;
		i_done = 1'b0;
		@(posedge clk);
		pc_addr   <= pc;
		data_addr <= addr;
		data_in   <= wdata;
		mem_read  <= !is_store;
		mem_write <= is_store;
		while (!(d_done && i_done)) begin
			@(negedge clk);
			if (!d_done && !mem_stall) begin
				if (is_store) begin
					ref_mem[addr] = wdata; // commits on the coming edge
				end else begin
					check_value("d_out", d_out, model_read(addr));
				end
				d_done = 1'b1;
			end
			if (!i_done && !if_stall) begin
				check_value("i_out", i_out, model_read(pc));
				i_done = 1'b1;
			end
			@(posedge clk);
			if (d_done) begin
				mem_read  <= 1'b0;
				mem_write <= 1'b0;
			end
		end
	endtask

	// 4 tags over sets 5 and 6, so blocks keep evicting each other
	task automatic test_random_mix();
		logic [15:0] pc;
		logic [15:0] addr;
		logic        is_store;
		logic [15:0] wdata;
		for (int k = 0; k < RANDOM_OPS; k++) begin
			pc       = 16'hC000 + 16'(($urandom % 256) * 2); // spans 32 I blocks
			addr     = make_addr(6'($urandom % 4), 6'(5 + $urandom % 2), 3'($urandom % 8));
			is_store = 1'($urandom % 2);
			wdata    = 16'($urandom);
			run_access(pc, addr, is_store, wdata);
		end
	endtask

	initial begin
		int unsigned seed_out;
		seed_out  = $urandom(32'h2193); // one seed for the whole run
		clk       = 1'b0;
		rst_n     = 1'b0;
		pc_addr   = 16'hC000;
		data_addr = 16'h0000;
		data_in   = 16'h0000;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_state();
		test_read_fill();
		test_write_allocate();
		test_priority();
		test_random_mix();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: list.f
source/cache_pkg.sv
source/port_if.sv
source/l1_cache.sv
source/miss_arbiter.sv
source/fill_ctrl.sv
source/main_memory.sv
source/cache_subsystem.sv
test/tb_cache_subsystem.sv
